/* ring_soc.f */
+incdir+hdl
hdl/ring_pkg.sv
hdl/nic_bus_if.sv
hdl/ring_stop.sv
hdl/nic_decode.sv
hdl/nic_execute.sv
hdl/nic_result.sv
hdl/ring_soc.sv
tb/ring_soc_tb.sv

/* Makefile */
TOP = ring_soc_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f ring_soc.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

/* tb/ring_soc_tb.sv */
`timescale 1ns/1ps
`include "ring_settings.svh"

module ring_soc_tb import ring_pkg::*; ();

	// requests issued over all tests
	localparam int N_TRANS = 50;
	localparam int WORDS   = 2 ** `MEM_AWIDTH;

	logic                               clk100;
	logic                               arst_n;
	logic      [`RING_HOSTS-1:0]        host_inject;
	pkt_kind_e [`RING_HOSTS-1:0]        host_kind;
	node_id_t  [`RING_HOSTS-1:0]        host_dst;
	logic      [`RING_HOSTS-1:0][15:0]  host_adr;
	logic      [`RING_HOSTS-1:0][31:0]  host_dat;
	logic      [`RING_HOSTS-1:0]        host_busy;
	logic      [`RING_HOSTS-1:0]        host_take;
	pkt_kind_e [`RING_HOSTS-1:0]        take_kind;
	node_id_t  [`RING_HOSTS-1:0]        take_src;
	logic      [`RING_HOSTS-1:0][15:0]  take_adr;
	logic      [`RING_HOSTS-1:0][31:0]  take_dat;

	// reference copy of the shared memory
	logic [31:0] ref_mem [WORDS];
	int          errors;
	int          checks;

	ring_soc dut_i (
		.clk100(clk100), .arst_n_i(arst_n),
		.host_inject_i(host_inject), .host_kind_i(host_kind), .host_dst_i(host_dst),
		.host_adr_i(host_adr), .host_dat_i(host_dat), .host_busy_o(host_busy),
		.host_take_o(host_take), .host_kind_o(take_kind), .host_src_o(take_src),
		.host_adr_o(take_adr), .host_dat_o(take_dat)
	);

	// 100 MHz
	always #5 clk100 = ~clk100;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	task automatic report(input string msg);
		errors++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	// host index h is stop id h+1; called on a falling edge
	task automatic send_packet(input int h, input pkt_kind_e kind, input node_id_t dst,
			input logic [15:0] adr, input logic [31:0] dat);
		while (host_busy[h])
			@(negedge clk100);
		host_inject[h] = 1'b1;
		host_kind[h]   = kind;
		host_dst[h]    = dst;
		host_adr[h]    = adr;
		host_dat[h]    = dat;
		@(negedge clk100);
		host_inject[h] = 1'b0;
	endtask

	// take is a one-cycle pulse, sampled mid cycle
	task automatic await_take(input int h, output bit got);
		int n;
		got = 1'b0;
		n = 0;
		while (!got && n < 150) begin
			@(negedge clk100);
			got = host_take[h];
			n++;
		end
		if (!got) begin
			errors++;
			$display("no packet reached host %0d within %0d cycles", h + 1, n);
		end
	endtask

	task automatic check_reply(input int h, input pkt_kind_e kind, input node_id_t src,
			input logic [15:0] adr, input logic [31:0] dat);
		checks++;
		if (take_kind[h] !== kind)
			report($sformatf("host %0d kind %0d, expected %0d", h + 1, take_kind[h], kind));
		if (take_src[h] !== src)
			report($sformatf("host %0d src %0d, expected %0d", h + 1, take_src[h], src));
		if (take_adr[h] !== adr)
			report($sformatf("host %0d adr %h, expected %h", h + 1, take_adr[h], adr));
		if (take_dat[h] !== dat)
			report($sformatf("host %0d dat %h, expected %h", h + 1, take_dat[h], dat));
	endtask

	// one request to the system stop and its reply
	task automatic mem_access(input int h, input bit wr, input logic [15:0] adr,
			input logic [31:0] dat);
		logic [31:0] exp_dat;
		bit          got;
		// writes echo the new word
		exp_dat = wr ? dat : ref_mem[adr[`MEM_AWIDTH-1:0]];
		if (wr)
			ref_mem[adr[`MEM_AWIDTH-1:0]] = dat;
		send_packet(h, wr ? WR_REQ : RD_REQ, node_id_t'(`NIC_ID), adr, dat);
		await_take(h, got);
		if (got)
			check_reply(h, RD_RESP, node_id_t'(`NIC_ID), adr, exp_dat);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------

	task automatic test_reset_state();
		repeat (8) begin
			@(negedge clk100);
			checks++;
			if (host_busy !== '0 || host_take !== '0)
				report($sformatf("busy %b take %b after reset", host_busy, host_take));
		end
		mem_access(0, 1'b0, 16'h0000, '0);
		mem_access(1, 1'b0, 16'h00ff, '0);
		mem_access(0, 1'b0, 16'($urandom), '0);
	endtask

	task automatic test_write_read();
		mem_access(0, 1'b1, 16'h0012, 32'hdead_beef);
		mem_access(0, 1'b0, 16'h0012, '0);
	endtask

	task automatic test_shared_memory();
		mem_access(1, 1'b1, 16'h0040, 32'h1234_5678);
		mem_access(0, 1'b0, 16'h0040, '0);
	endtask

	// both stops inject in the same cycle
	task automatic test_both_hosts();
		int          seen [2];
		int          n;
		logic [31:0] wd [2];
		logic [15:0] wa [2];
		wa[0] = 16'h0021;
		wa[1] = 16'h0022;
		wd[0] = $urandom;
		wd[1] = $urandom;
		seen  = '{0, 0};
		n     = 0;
		while (host_busy != '0)
			@(negedge clk100);
		for (int h = 0; h < 2; h++) begin
			host_inject[h] = 1'b1;
			host_kind[h]   = WR_REQ;
			host_dst[h]    = node_id_t'(`NIC_ID);
			host_adr[h]    = wa[h];
			host_dat[h]    = wd[h];
			ref_mem[wa[h][`MEM_AWIDTH-1:0]] = wd[h];
		end
		@(negedge clk100);
		host_inject = '0;
		// wait for both, then watch a while for extra replies
		while (n < 170 && (n < 150 ? (seen[0] == 0 || seen[1] == 0) : 1'b1)) begin
			@(negedge clk100);
			for (int h = 0; h < 2; h++)
				if (host_take[h]) begin
					seen[h]++;
					check_reply(h, RD_RESP, node_id_t'(`NIC_ID), wa[h], wd[h]);
				end
			if (seen[0] != 0 && seen[1] != 0 && n < 150)
				n = 150;
			n++;
		end
		for (int h = 0; h < 2; h++)
			if (seen[h] != 1) begin
				errors++;
				$display("host %0d got %0d replies to one request", h + 1, seen[h]);
			end
	endtask

	// host to host, bypasses the system stop
	task automatic test_message();
		logic [31:0] d;
		bit          got;
		d = $urandom;
		send_packet(0, MSG, node_id_t'(2), 16'h1234, d);
		await_take(1, got);
		if (got)
			check_reply(1, MSG, node_id_t'(1), 16'h1234, d);
	endtask

	task automatic test_random();
		logic [15:0] a;
		for (int i = 0; i < 40; i++) begin
			// few low address bits, so reads hit earlier writes
			a = {8'($urandom), 4'h0, 4'($urandom)};
			mem_access(int'($urandom % 2), bit'($urandom % 2), a, $urandom);
		end
	endtask

	// --------------------------------------------------
	// run
	// --------------------------------------------------

	initial begin
		repeat (N_TRANS * 200) @(posedge clk100);
		$display("watchdog expired before the tests finished");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hc7de_5d59));
		clk100      = 1'b0;
		arst_n      = 1'b0;
		host_inject = '0;
		host_kind   = {MSG, MSG};
		host_dst    = '0;
		host_adr    = '0;
		host_dat    = '0;
		errors      = 0;
		checks      = 0;
		for (int i = 0; i < WORDS; i++)
			ref_mem[i] = '0;
		repeat (4) @(negedge clk100);
		arst_n = 1'b1;
		test_reset_state();
		test_write_read();
		test_shared_memory();
		test_both_hosts();
		test_message();
		test_random();
		repeat (4) @(negedge clk100);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* hdl/ring_soc.sv */
`timescale 1ns/1ps
`include "ring_settings.svh"

module ring_soc import ring_pkg::*; (
	input  logic                               clk100,
	input  logic                               arst_n_i,
	// host injection side
	input  logic      [`RING_HOSTS-1:0]        host_inject_i,
	input  pkt_kind_e [`RING_HOSTS-1:0]        host_kind_i,
	input  node_id_t  [`RING_HOSTS-1:0]        host_dst_i,
	input  logic      [`RING_HOSTS-1:0][15:0]  host_adr_i,
	input  logic      [`RING_HOSTS-1:0][31:0]  host_dat_i,
	output logic      [`RING_HOSTS-1:0]        host_busy_o,
	// host delivery side
	output logic      [`RING_HOSTS-1:0]        host_take_o,
	output pkt_kind_e [`RING_HOSTS-1:0]        host_kind_o,
	output node_id_t  [`RING_HOSTS-1:0]        host_src_o,
	output logic      [`RING_HOSTS-1:0][15:0]  host_adr_o,
	output logic      [`RING_HOSTS-1:0][31:0]  host_dat_o
);

	// ring[h] leaves host stop h, ring[RING_HOSTS] leaves the system stop
	packet_t ring [`RING_HOSTS+1];
	packet_t host_pkt [`RING_HOSTS];
	packet_t host_take_pkt [`RING_HOSTS];
	logic    nic_take;
	logic    nic_busy;
	logic    res_inject;
	logic    hdr_valid;
	packet_t nic_take_pkt;
	packet_t res_pkt;
	packet_t hdr;

	nic_bus_if bus_if ();

	// --------------------------------------------------
	// host stops, ids 1 and up
	// --------------------------------------------------

	for (genvar h = 0; h < `RING_HOSTS; h++) begin : gen_host
		// src is always the host's own stop id
		assign host_pkt[h] = '{valid: 1'b1, kind: host_kind_i[h], dst: host_dst_i[h],
			src: node_id_t'(h + 1), adr: host_adr_i[h], dat: host_dat_i[h], spare: 1'b0};

		assign host_kind_o[h] = host_take_pkt[h].kind;
		assign host_src_o[h]  = host_take_pkt[h].src;
		assign host_adr_o[h]  = host_take_pkt[h].adr;
		assign host_dat_o[h]  = host_take_pkt[h].dat;

		// input is the stop before, the system stop for host 1
		ring_stop #(.NODE_ID(node_id_t'(h + 1))) stop_i (
			.clk100(clk100), .arst_n_i(arst_n_i),
			.ring_i(ring[(h + `RING_HOSTS) % (`RING_HOSTS + 1)]), .ring_o(ring[h]),
			.inject_i(host_inject_i[h]), .inject_pkt_i(host_pkt[h]),
			.busy_o(host_busy_o[h]),
			.take_o(host_take_o[h]), .take_pkt_o(host_take_pkt[h])
		);
	end

	// --------------------------------------------------
	// system stop and nic chain
	// --------------------------------------------------

	ring_stop #(.NODE_ID(node_id_t'(`NIC_ID))) nic_stop_i (
		.clk100(clk100), .arst_n_i(arst_n_i),
		.ring_i(ring[`RING_HOSTS-1]), .ring_o(ring[`RING_HOSTS]),
		.inject_i(res_inject), .inject_pkt_i(res_pkt), .busy_o(nic_busy),
		.take_o(nic_take), .take_pkt_o(nic_take_pkt)
	);

	nic_decode decode_i (
		.clk100(clk100), .arst_n_i(arst_n_i),
		.take_i(nic_take), .take_pkt_i(nic_take_pkt), .bus(bus_if.master),
		.hdr_valid_o(hdr_valid), .hdr_o(hdr)
	);

	nic_execute execute_i (
		.clk100(clk100), .arst_n_i(arst_n_i), .bus(bus_if.slave)
	);

	// read data taken straight off the bus
	nic_result result_i (
		.clk100(clk100), .arst_n_i(arst_n_i),
		.hdr_valid_i(hdr_valid), .hdr_i(hdr), .rdat_i(bus_if.rdat),
		.stop_busy_i(nic_busy), .inject_o(res_inject), .inject_pkt_o(res_pkt)
	);

endmodule

/* hdl/nic_result.sv */
`timescale 1ns/1ps
`include "ring_settings.svh"

module nic_result import ring_pkg::*; (
	input  logic        clk100,
	input  logic        arst_n_i,
	input  logic        hdr_valid_i,
	input  packet_t     hdr_i,
	input  logic [31:0] rdat_i,
	input  logic        stop_busy_i,
	output logic        inject_o,
	output packet_t     inject_pkt_o
);

	localparam int DEPTH = `RESULT_DEPTH;
	localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// --------------------------------------------------
	// reply queue
	// --------------------------------------------------

	packet_t       q [DEPTH];
	packet_t       merged;
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;

	// header plus read data
	always_comb begin
		merged     = hdr_i;
		merged.dat = rdat_i;
	end

	// head goes out while the stop buffer is free
	// busy rises next cycle, so one packet per strobe
	assign inject_o     = (count != '0) && !stop_busy_i;
	assign inject_pkt_o = q[rd_ptr];

	always_ff @(posedge clk100 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (hdr_valid_i)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (inject_o)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// push and pop together leave count alone
			if (hdr_valid_i && !inject_o)
				count <= count + 1'b1;
			else if (!hdr_valid_i && inject_o)
				count <= count - 1'b1;
		end
	end

	// queue storage, no reset
	always_ff @(posedge clk100) begin
		if (hdr_valid_i)
			q[wr_ptr] <= merged;
	end

	// ack into a full queue loses a reply
	a_overflow: assert property (
		@(posedge clk100) disable iff (!arst_n_i)
		hdr_valid_i |-> (count < DEPTH) || inject_o
	);

endmodule

/* hdl/nic_execute.sv */
`timescale 1ns/1ps
`include "ring_settings.svh"

module nic_execute (
	input  logic     clk100,
	input  logic     arst_n_i,
	nic_bus_if.slave bus
);

	localparam int WORDS = 2 ** `MEM_AWIDTH;

	// shared word memory
	logic [31:0] mem [WORDS];

	// --------------------------------------------------
	// write port and ack
	// --------------------------------------------------

	always_ff @(posedge clk100 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bus.ack <= 1'b0;
			// memory starts all zero
			for (int i = 0; i < WORDS; i++)
				mem[i] <= '0;
		end else begin
			// ack one cycle after cyc
			bus.ack <= bus.cyc;
			if (bus.cyc && bus.we)
				mem[bus.adr] <= bus.wdat;
		end
	end

	// read data, a write returns the new word
	always_ff @(posedge clk100) begin
		if (bus.cyc)
			bus.rdat <= bus.we ? bus.wdat : mem[bus.adr];
	end

	// decode spaces its cycles, so cyc never lasts two cycles
	a_cyc_single: assert property (
		@(posedge clk100) disable iff (!arst_n_i)
		bus.cyc |=> !bus.cyc
	);

endmodule

/* hdl/nic_decode.sv */
`timescale 1ns/1ps
`include "ring_settings.svh"

module nic_decode import ring_pkg::*; (
	input  logic      clk100,
	input  logic      arst_n_i,
	input  logic      take_i,
	input  packet_t   take_pkt_i,
	nic_bus_if.master bus,
	output logic      hdr_valid_o,
	output packet_t   hdr_o
);

	logic    req_in;
	logic    issue;
	logic    pend_valid;
	packet_t pend_pkt;
	packet_t issue_pkt;

	// only requests start a bus cycle
	assign req_in = take_i && (take_pkt_i.kind == RD_REQ || take_pkt_i.kind == WR_REQ);
	// one idle cycle between cycles
	// a second request waits in pend
	assign issue     = !bus.cyc && (pend_valid || req_in);
	assign issue_pkt = pend_valid ? pend_pkt : take_pkt_i;

	// reply header is ready with the ack
	assign hdr_valid_o = bus.ack;

	always_ff @(posedge clk100 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bus.cyc    <= 1'b0;
			pend_valid <= 1'b0;
		end else begin
			bus.cyc <= issue;
			if (req_in && (bus.cyc || pend_valid))
				pend_valid <= 1'b1;
			else if (issue)
				pend_valid <= 1'b0;
		end
	end

	// request fields and reply header
	always_ff @(posedge clk100) begin
		if (req_in && (bus.cyc || pend_valid))
			pend_pkt <= take_pkt_i;
		if (issue) begin
			bus.we   <= (issue_pkt.kind == WR_REQ);
			bus.adr  <= issue_pkt.adr[`MEM_AWIDTH-1:0];
			bus.wdat <= issue_pkt.dat;
			// reply goes back to the sender
			hdr_o <= '{valid: 1'b1, kind: RD_RESP, dst: issue_pkt.src,
				src: node_id_t'(`NIC_ID), adr: issue_pkt.adr, dat: '0, spare: 1'b0};
		end
	end

	// msg packets have no business at the system stop
	a_no_msg: assert property (
		@(posedge clk100) disable iff (!arst_n_i)
		take_i |-> take_pkt_i.kind != MSG
	);

	// a third request in flight would overwrite pend
	a_pend_overflow: assert property (
		@(posedge clk100) disable iff (!arst_n_i)
		req_in |-> !(bus.cyc && pend_valid)
	);

endmodule

/* hdl/ring_stop.sv */
`timescale 1ns/1ps

module ring_stop import ring_pkg::*; #(
	parameter node_id_t NODE_ID = 6'd1
) (
	input  logic    clk100,
	input  logic    arst_n_i,
	// ring in from the previous stop, ring out to the next
	input  packet_t ring_i,
	output packet_t ring_o,
	// local injection
	input  logic    inject_i,
	input  packet_t inject_pkt_i,
	output logic    busy_o,
	// local delivery
	output logic    take_o,
	output packet_t take_pkt_o
);

	// --------------------------------------------------
	// slot decode
	// --------------------------------------------------

	logic    taken;
	logic    slot_free;
	logic    inj_valid;
	packet_t inj_pkt;

	// packet addressed to this stop
	assign taken = ring_i.valid && (ring_i.dst == NODE_ID);
	// empty slot, or one emptied by the take
	assign slot_free = !ring_i.valid || taken;

	// buffer full means busy
	assign busy_o = inj_valid;

	// --------------------------------------------------
	// ring register and control
	// --------------------------------------------------

	always_ff @(posedge clk100 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ring_o    <= '0;
			take_o    <= 1'b0;
			inj_valid <= 1'b0;
		end else begin
			take_o <= taken;
			// buffered packet claims a free slot
			if (slot_free && inj_valid)
				ring_o <= inj_pkt;
			else if (taken)
				ring_o <= '0;
			else
				ring_o <= ring_i;
			// drain first, a new strobe refills
			if (slot_free && inj_valid)
				inj_valid <= 1'b0;
			if (inject_i)
				inj_valid <= 1'b1;
		end
	end

	// payload, no reset
	always_ff @(posedge clk100) begin
		if (inject_i)
			inj_pkt <= inject_pkt_i;
		if (taken)
			take_pkt_o <= ring_i;
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// the local user must wait for busy low
	a_inject_busy: assert property (
		@(posedge clk100) disable iff (!arst_n_i)
		inject_i |-> !busy_o
	);

endmodule

/* hdl/nic_bus_if.sv */
`timescale 1ns/1ps
`include "ring_settings.svh"

// local word bus between decode and execute
// one cycle of cyc per request, ack follows in the next cycle
interface nic_bus_if;
	logic                   cyc;
	logic                   we;
	logic [`MEM_AWIDTH-1:0] adr;
	logic [31:0]            wdat;
	// read data, valid together with ack
	logic [31:0]            rdat;
	logic                   ack;

	// request side
	modport master (
		output cyc, we, adr, wdat,
		input  rdat, ack
	);

	// memory side
	modport slave (
		input  cyc, we, adr, wdat,
		output rdat, ack
	);
endinterface

/* hdl/ring_pkg.sv */
package ring_pkg;

	// 6-bit ring stop id
	typedef logic [5:0] node_id_t;

	// packet kinds
	// a write is answered with RD_RESP carrying the written word
	typedef enum logic [1:0] {
		MSG     = 2'd0,
		RD_REQ  = 2'd1,
		WR_REQ  = 2'd2,
		RD_RESP = 2'd3
	} pkt_kind_e;

	// one ring slot, 64 bits
	typedef struct packed {
		logic      valid;
		pkt_kind_e kind;
		node_id_t  dst;
		node_id_t  src;
		// word address, memory uses the low bits only
		logic [15:0] adr;
		logic [31:0] dat;
		// pads to 64
		logic      spare;
	} packet_t;

endpackage

/* hdl/ring_settings.svh */
`ifndef RING_SETTINGS_SVH
`define RING_SETTINGS_SVH

// number of host stops on the ring
`define RING_HOSTS 2

// stop id of the system network interface
`define NIC_ID 62

// word address width, 2**8 = 256 words
`define MEM_AWIDTH 8

// reply queue entries, never fewer than RING_HOSTS
`define RESULT_DEPTH 4

`endif
